// ==== verilog/car_game_config.svh ====
/* Timing, game size, display patterns and MAX7219 settings for the car game */

`ifndef CAR_GAME_CONFIG_SVH
`define CAR_GAME_CONFIG_SVH

// ---------------------------------------------------------------------------
// Timing
// ---------------------------------------------------------------------------
`define DEBOUNCE_CYCLES 256
`define TICK_CYCLES     4096

// ---------------------------------------------------------------------------
// Game size and screen patterns
// ---------------------------------------------------------------------------
`define LEVEL_TICKS     8
`define NUM_LEVELS      2
`define IDLE_ROW        8'h7C
`define OVER_ROW        8'h10

// ---------------------------------------------------------------------------
// MAX7219 link
// ---------------------------------------------------------------------------
`define MAX_INTENSITY   4'hA
`define SCLK_HALF       2
`define NCS_GAP         4

`endif

// ==== verilog/game_pkg.sv ====
/* Game types: row, level and progress widths, mode enum and frame struct */

`default_nettype none

package game_pkg;

	// One matrix row, bit 7 is the leftmost LED
	typedef logic [7:0] row_t;

	typedef logic [1:0] level_t;
	typedef logic [2:0] progress_t;

	typedef enum logic [1:0] {
		idle = 2'd0,
		play = 2'd1,
		over = 2'd2
	} game_mode_e;

	// Whole screen, row0 is where new obstacles enter
	typedef struct packed {
		row_t row0;
		row_t row1;
		row_t row2;
		row_t row3;
		row_t row4;
		row_t row5;
		row_t row6;
		row_t row7;
	} frame_t;

endpackage

`default_nettype wire

// ==== verilog/display_pkg.sv ====
/* MAX7219 register map, serial word layout and driver sequencer states */

`default_nettype none

package display_pkg;

	typedef enum logic [3:0] {
		no_op        = 4'h0,
		digit_1      = 4'h1,
		digit_2      = 4'h2,
		digit_3      = 4'h3,
		digit_4      = 4'h4,
		digit_5      = 4'h5,
		digit_6      = 4'h6,
		digit_7      = 4'h7,
		digit_8      = 4'h8,
		decode_mode  = 4'h9,
		intensity    = 4'hA,
		scan_limit   = 4'hB,
		shutdown     = 4'hC,
		display_test = 4'hF
	} max_addr_e;

	// 16-bit word as shifted out, MSB first
	typedef struct packed {
		logic [3:0] dont_care;
		max_addr_e  addr;
		logic [7:0] data;
	} max_word_t;

	typedef enum logic [1:0] {
		drv_gap   = 2'd0,
		drv_load  = 2'd1,
		drv_shift = 2'd2
	} drv_state_e;

endpackage

`default_nettype wire

// ==== verilog/button_debounce.sv ====
/* Start button synchronizer, stability counter and press pulse */

`timescale 1ns/1ps
`default_nettype none

`include "car_game_config.svh"

module button_debounce (
	input  logic clock_50,
	input  logic rst_n,
	input  logic start_n,
	output logic start_press
);

	localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES);

	logic             sync_1;
	logic             sync_2;
	logic             stable;
	logic [CNT_W-1:0] stable_cnt;

	// Two flops into the clock domain, button idles high
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			sync_1 <= 1'b1;
			sync_2 <= 1'b1;
		end else begin
			sync_1 <= start_n;
			sync_2 <= sync_1;
		end
	end

	// Level must differ for DEBOUNCE_CYCLES samples in a row
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			stable      <= 1'b1;
			stable_cnt  <= '0;
			start_press <= 1'b0;
		end else begin
			start_press <= 1'b0;
			if (sync_2 == stable) begin
				stable_cnt <= '0;
			end else if (stable_cnt == CNT_W'(`DEBOUNCE_CYCLES - 1)) begin
				stable_cnt  <= '0;
				stable      <= sync_2;
				// Press on the falling edge only
				start_press <= stable & ~sync_2;
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/game_control.sv ====
/* Game mode FSM, tick prescaler and level progress counters */

`timescale 1ns/1ps
`default_nettype none

`include "car_game_config.svh"

module game_control
	import game_pkg::*;
(
	input  logic       clock_50,
	input  logic       rst_n,
	input  logic       start_press,
	output game_mode_e mode,
	output logic       tick,
	output logic       play_start,
	output level_t     level,
	output progress_t  progress
);

	localparam int PRESC_W = $clog2(`TICK_CYCLES);

	logic [PRESC_W-1:0] presc;
	// Last level wrapped, final frame is on screen
	logic               last_done;

	// ------------------------------------------------------------------------
	// Mode FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			mode       <= idle;
			play_start <= 1'b0;
		end else begin
			play_start <= 1'b0;
			case (mode)
				idle: begin
					if (start_press) begin
						mode       <= play;
						play_start <= 1'b1;
					end
				end
				play: begin
					// Final frame stays up for one full tick
					if (tick && last_done) begin
						mode <= over;
					end
				end
				over: begin
					if (start_press) begin
						mode <= idle;
					end
				end
				default: mode <= idle;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Speed prescaler, held at zero outside play
	// ------------------------------------------------------------------------
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			presc <= '0;
			tick  <= 1'b0;
		end else begin
			tick <= 1'b0;
			if (mode != play) begin
				presc <= '0;
			end else if (presc == PRESC_W'(`TICK_CYCLES - 1)) begin
				presc <= '0;
				tick  <= 1'b1;
			end else begin
				presc <= presc + 1'b1;
			end
		end
	end

	// Progress within a level, then level
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			level     <= '0;
			progress  <= '0;
			last_done <= 1'b0;
		end else if (play_start) begin
			level     <= '0;
			progress  <= '0;
			last_done <= 1'b0;
		end else if (tick) begin
			progress <= progress + 1'b1;
			if (progress == progress_t'(`LEVEL_TICKS - 1)) begin
				progress <= '0;
				if (level == level_t'(`NUM_LEVELS - 1)) begin
					last_done <= 1'b1;
				end else begin
					level <= level + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/road_scroll.sv ====
/* Obstacle generator, scrolling row register and per-mode frame select */

`timescale 1ns/1ps
`default_nettype none

`include "car_game_config.svh"

module road_scroll
	import game_pkg::*;
(
	input  logic       clock_50,
	input  logic       rst_n,
	input  game_mode_e mode,
	input  logic       tick,
	input  logic       play_start,
	input  level_t     level,
	input  progress_t  progress,
	output frame_t     frame
);

	row_t       rows_q [8];
	row_t       shown  [8];
	logic [2:0] obstacle_pos;
	row_t       obstacle;

	// Lane is (progress * 3 + level) mod 8
	assign obstacle_pos = 3'((5'(progress) * 5'd3) + 5'(level));
	assign obstacle     = row_t'(8'd1 << obstacle_pos);

	// Road moves one row per tick, new obstacle enters at row0
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < 8; r++) begin
				rows_q[r] <= '0;
			end
		end else if (play_start) begin
			for (int r = 0; r < 8; r++) begin
				rows_q[r] <= '0;
			end
		end else if (tick) begin
			for (int r = 7; r > 0; r--) begin
				rows_q[r] <= rows_q[r-1];
			end
			rows_q[0] <= obstacle;
		end
	end

	always_comb begin
		for (int r = 0; r < 8; r++) begin
			case (mode)
				idle:    shown[r] = `IDLE_ROW;
				play:    shown[r] = rows_q[r];
				default: shown[r] = `OVER_ROW;
			endcase
		end
	end

	assign frame = '{row0: shown[0], row1: shown[1], row2: shown[2], row3: shown[3],
	                 row4: shown[4], row5: shown[5], row6: shown[6], row7: shown[7]};

endmodule

`default_nettype wire

// ==== verilog/matrix_driver.sv ====
/* MAX7219 init and refresh sequencer, row to column transpose,
   serial shifter for din, ncs and the serial clock */

`timescale 1ns/1ps
`default_nettype none

`include "car_game_config.svh"

module matrix_driver
	import game_pkg::*;
	import display_pkg::*;
(
	input  logic   clock_50,
	input  logic   rst_n,
	input  frame_t frame,
	output logic   max7219_din,
	output logic   max7219_ncs,
	output logic   max7219_clk
);

	// Words 0..4 are init, 5..12 are digits 1..8
	localparam logic [3:0] INIT_WORDS  = 4'd4;
	localparam logic [3:0] FIRST_DIGIT = 4'd5;
	localparam logic [3:0] LAST_DIGIT  = 4'd12;
	localparam logic [3:0] HALF_LAST   = 4'(`SCLK_HALF - 1);
	// Load cycle adds one more ncs high cycle
	localparam logic [3:0] GAP_LAST    = 4'(`NCS_GAP - 2);

	drv_state_e  state;
	logic [3:0]  seq_idx;
	logic [3:0]  next_idx;
	logic [3:0]  half_cnt;
	logic [3:0]  bit_cnt;
	logic [3:0]  gap_cnt;
	logic [15:0] shift_word;
	frame_t      frame_q;
	frame_t      pass_frame;
	row_t        src_rows [8];
	logic [2:0]  col;
	max_word_t   word;

	assign next_idx = (seq_idx == LAST_DIGIT) ? FIRST_DIGIT : seq_idx + 4'd1;

	// Digit 1 reads the live frame, the rest of the pass the latched copy
	assign pass_frame  = (seq_idx == FIRST_DIGIT) ? frame : frame_q;
	assign src_rows[0] = pass_frame.row0;
	assign src_rows[1] = pass_frame.row1;
	assign src_rows[2] = pass_frame.row2;
	assign src_rows[3] = pass_frame.row3;
	assign src_rows[4] = pass_frame.row4;
	assign src_rows[5] = pass_frame.row5;
	assign src_rows[6] = pass_frame.row6;
	assign src_rows[7] = pass_frame.row7;

	// Digit d shows column 8-d
	assign col = 3'(LAST_DIGIT - seq_idx);

	// ------------------------------------------------------------------------
	// Word for the current sequence slot
	// ------------------------------------------------------------------------
	always_comb begin
		word = '{dont_care: 4'h0, addr: no_op, data: 8'h00};
		case (seq_idx)
			4'd0: word = '{dont_care: 4'h0, addr: shutdown, data: 8'h00};
			4'd1: word = '{dont_care: 4'h0, addr: decode_mode, data: 8'h00};
			4'd2: word = '{dont_care: 4'h0, addr: scan_limit, data: 8'h07};
			4'd3: word = '{dont_care: 4'h0, addr: intensity, data: 8'(`MAX_INTENSITY)};
			4'd4: word = '{dont_care: 4'h0, addr: display_test, data: 8'h00};
			default: begin
				word.addr = max_addr_e'(seq_idx - INIT_WORDS);
				// Row r lands on bit 7-r of the digit
				for (int r = 0; r < 8; r++) begin
					word.data[7 - r] = src_rows[r][col];
				end
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// Sequencer and serial shifter
	// ------------------------------------------------------------------------
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			state       <= drv_gap;
			seq_idx     <= '0;
			half_cnt    <= '0;
			bit_cnt     <= '0;
			gap_cnt     <= '0;
			shift_word  <= '0;
			max7219_ncs <= 1'b1;
			max7219_clk <= 1'b0;
		end else begin
			case (state)
				drv_gap: begin
					if (gap_cnt == GAP_LAST) begin
						gap_cnt <= '0;
						state   <= drv_load;
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				drv_load: begin
					shift_word  <= word;
					max7219_ncs <= 1'b0;
					half_cnt    <= '0;
					bit_cnt     <= '0;
					state       <= drv_shift;
				end
				drv_shift: begin
					if (half_cnt == HALF_LAST) begin
						half_cnt    <= '0;
						max7219_clk <= ~max7219_clk;
						// Next bit goes out on the falling edge
						if (max7219_clk) begin
							shift_word <= {shift_word[14:0], 1'b0};
							bit_cnt    <= bit_cnt + 1'b1;
							if (bit_cnt == 4'd15) begin
								max7219_ncs <= 1'b1;
								seq_idx     <= next_idx;
								state       <= drv_gap;
							end
						end
					end else begin
						half_cnt <= half_cnt + 1'b1;
					end
				end
				default: state <= drv_gap;
			endcase
		end
	end

	// Frame held for the whole refresh pass
	always_ff @(posedge clock_50) begin
		if (state == drv_load && seq_idx == FIRST_DIGIT) begin
			frame_q <= frame;
		end
	end

	assign max7219_din = shift_word[15];

endmodule

`default_nettype wire

// ==== verilog/car_game_top.sv ====
/* Car game top level: debounce, game control, road scroll, matrix driver */

`timescale 1ns/1ps
`default_nettype none

module car_game_top
	import game_pkg::*;
(
	input  logic clock_50,
	input  logic rst_n,
	input  logic start_n,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk
);

	logic       start_press;
	game_mode_e mode;
	logic       tick;
	logic       play_start;
	level_t     level;
	progress_t  progress;
	frame_t     frame;

	button_debounce i_button_debounce (
		.clock_50    (clock_50),
		.rst_n       (rst_n),
		.start_n     (start_n),
		.start_press (start_press)
	);

	game_control i_game_control (
		.clock_50    (clock_50),
		.rst_n       (rst_n),
		.start_press (start_press),
		.mode        (mode),
		.tick        (tick),
		.play_start  (play_start),
		.level       (level),
		.progress    (progress)
	);

	road_scroll i_road_scroll (
		.clock_50   (clock_50),
		.rst_n      (rst_n),
		.mode       (mode),
		.tick       (tick),
		.play_start (play_start),
		.level      (level),
		.progress   (progress),
		.frame      (frame)
	);

	// Display side only samples the latest frame
	matrix_driver i_matrix_driver (
		.clock_50    (clock_50),
		.rst_n       (rst_n),
		.frame       (frame),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

endmodule

`default_nettype wire

// ==== tb/max7219_monitor.sv ====
/* MAX7219 serial link decoder, one 16-bit word per ncs frame */

`timescale 1ns/1ps
`default_nettype none

module max7219_monitor (
	input  logic        clock_50,
	input  logic        rst_n,
	input  logic        max7219_din,
	input  logic        max7219_ncs,
	input  logic        max7219_clk,
	output logic [15:0] word,
	output logic [4:0]  word_bits,
	output logic        word_valid
);

	logic        clk_q;
	logic        ncs_q;
	logic [15:0] shift;
	logic [4:0]  bits;

	// Serial clock is slow, so edges are found by sampling with clock_50
	always_ff @(posedge clock_50 or negedge rst_n) begin
		if (!rst_n) begin
			clk_q      <= 1'b0;
			ncs_q      <= 1'b1;
			shift      <= '0;
			bits       <= '0;
			word       <= '0;
			word_bits  <= '0;
			word_valid <= 1'b0;
		end else begin
			clk_q      <= max7219_clk;
			ncs_q      <= max7219_ncs;
			word_valid <= 1'b0;
			if (max7219_ncs && !ncs_q) begin
				// Word ends when ncs rises
				word       <= shift;
				word_bits  <= bits;
				word_valid <= 1'b1;
				bits       <= '0;
			end else if (!max7219_ncs && max7219_clk && !clk_q) begin
				shift <= {shift[14:0], max7219_din};
				bits  <= bits + 5'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_car_game.sv ====
/* Car game testbench with clock, reset, golden file reader and button stimulus,
   init word and refresh pass checks and a watchdog */

`timescale 1ns/1ps
`default_nettype none

`include "car_game_config.svh"

module tb_car_game;

	// Eight bytes with row0 or digit 1 at index 0
	typedef logic [7:0][7:0] pass_t;

	logic        clock_50;
	logic        rst_n;
	logic        start_n;
	logic        max7219_din;
	logic        max7219_ncs;
	logic        max7219_clk;
	logic [15:0] mon_word;
	logic [4:0]  mon_bits;
	logic        mon_valid;

	// One golden command per tagged line
	string       cmd_tag [$];
	string       cmd_name [$];
	int          cmd_arg [$];
	pass_t       cmd_rows [$];
	int          frame_lines;
	logic        golden_loaded;

	// Received words with their bit count on top
	logic [20:0] words [$];
	pass_t       cur_digits;
	logic        have_cur;
	logic [31:0] rng;
	string       test_name;
	int          test_errors;
	int          test_checks;
	int          tests_run;
	int          tests_failed;
	int          errors;
	int          checks;

	car_game_top i_car_game_top (
		.clock_50    (clock_50),
		.rst_n       (rst_n),
		.start_n     (start_n),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk)
	);

	max7219_monitor i_max7219_monitor (
		.clock_50    (clock_50),
		.rst_n       (rst_n),
		.max7219_din (max7219_din),
		.max7219_ncs (max7219_ncs),
		.max7219_clk (max7219_clk),
		.word        (mon_word),
		.word_bits   (mon_bits),
		.word_valid  (mon_valid)
	);

	always #10 clock_50 = ~clock_50;

	always @(posedge clock_50) begin
		if (mon_valid) begin
			words.push_back({mon_bits, mon_word});
		end
	end

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Digit d gets bit 8-d of row r on its bit 7-r
	function automatic pass_t digits_of(input pass_t rows);
		pass_t d;
		for (int k = 1; k <= 8; k++) begin
			for (int r = 0; r < 8; r++) begin
				d[k-1][7-r] = rows[r][8-k];
			end
		end
		return d;
	endfunction

	task automatic note_error();
		errors++;
		test_errors++;
	endtask

	task automatic count_check();
		checks++;
		test_checks++;
	endtask

	task automatic close_test();
		if (test_name != "") begin
			tests_run++;
			if (test_errors > 0) begin
				tests_failed++;
				$display("Test %s: FAILED, %0d errors in %0d checks", test_name, test_errors,
				         test_checks);
			end else begin
				$display("Test %s: ok, %0d checks", test_name, test_checks);
			end
		end
	endtask

	task automatic read_golden();
		int         fd;
		int         n;
		int         need;
		int         arg;
		string      line;
		string      tag;
		string      name;
		logic [7:0] r [8];
		pass_t      rows;
		fd = $fopen("tb/car_game_golden.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the golden file tb/car_game_golden.txt");
			errors++;
			return;
		end
		while ($fgets(line, fd) > 0) begin
			tag = "";
			n = $sscanf(line, "%s", tag);
			if (n != 1 || tag.getc(0) == "#") begin
				continue;
			end
			arg  = 0;
			name = "";
			rows = '0;
			need = 2;
			if (tag == "T") begin
				n = $sscanf(line, "%s %s", tag, name);
			end else if (tag == "F") begin
				need = 10;
				n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", tag, arg,
				            r[0], r[1], r[2], r[3], r[4], r[5], r[6], r[7]);
				for (int i = 0; i < 8; i++) begin
					rows[i] = r[i];
				end
				frame_lines++;
			end else begin
				n = $sscanf(line, "%s %h", tag, arg);
			end
			if (n < need) begin
				$display("Golden file line is malformed: %s", line);
				errors++;
			end
			cmd_tag.push_back(tag);
			cmd_name.push_back(name);
			cmd_arg.push_back(arg);
			cmd_rows.push_back(rows);
		end
		$fclose(fd);
	endtask

	task automatic next_word(output logic [15:0] w);
		logic [20:0] entry;
		while (words.size() == 0) begin
			@(posedge clock_50);
		end
		entry = words.pop_front();
		if (entry[20:16] != 5'd16) begin
			$display("Test %s: serial word carried %0d bits instead of 16", test_name,
			         entry[20:16]);
			note_error();
		end
		w = entry[15:0];
	endtask

	task automatic next_pass(output pass_t p);
		logic [15:0] w;
		for (int d = 1; d <= 8; d++) begin
			next_word(w);
			if (w[11:8] != 4'(d)) begin
				$display("Test %s: refresh word %0d came with address %h", test_name, d,
				         w[11:8]);
				note_error();
			end
			p[d-1] = w[7:0];
		end
	endtask

	task automatic expect_init_word(input logic [15:0] expected);
		logic [15:0] w;
		next_word(w);
		count_check();
		// Top nibble is don't care on the MAX7219
		if (w[11:0] != expected[11:0]) begin
			$display("Mismatch in %s: expected %h actual %h", test_name, expected, w);
			note_error();
		end
	endtask

	// Passes may still show the current frame until the new one arrives
	task automatic follow_frame(input pass_t rows, input int passes);
		pass_t want;
		pass_t got;
		want = digits_of(rows);
		if (!have_cur) begin
			cur_digits = want;
			have_cur   = 1'b1;
		end
		next_pass(got);
		while (got == cur_digits && got != want) begin
			next_pass(got);
		end
		for (int i = 0; i < passes; i++) begin
			if (i > 0) begin
				next_pass(got);
			end
			count_check();
			if (got != want) begin
				$display("Mismatch in %s: expected %h actual %h", test_name, want, got);
				note_error();
			end
		end
		cur_digits = want;
	endtask

	task automatic press_button(input int cycles);
		@(negedge clock_50);
		start_n = 1'b0;
		repeat (cycles) @(negedge clock_50);
		start_n = 1'b1;
	endtask

	// Low pulses too short for the debouncer
	task automatic glitch_button(input int count);
		int len;
		for (int i = 0; i < count; i++) begin
			rng = xorshift32(rng);
			len = 1 + int'(rng % 32'(`DEBOUNCE_CYCLES - 1));
			press_button(len);
			repeat (`DEBOUNCE_CYCLES) @(negedge clock_50);
		end
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin
		clock_50      = 1'b0;
		rst_n         = 1'b0;
		start_n       = 1'b1;
		rng           = 32'ha44;
		golden_loaded = 1'b0;
		have_cur      = 1'b0;
		cur_digits    = '0;
		frame_lines   = 0;
		test_name     = "";
		test_errors   = 0;
		test_checks   = 0;
		tests_run     = 0;
		tests_failed  = 0;
		errors        = 0;
		checks        = 0;
		read_golden();
		golden_loaded = 1'b1;
		repeat (16) @(posedge clock_50);
		@(negedge clock_50);
		rst_n = 1'b1;

		for (int i = 0; i < cmd_tag.size(); i++) begin
			if (cmd_tag[i] == "T") begin
				close_test();
				test_name   = cmd_name[i];
				test_errors = 0;
				test_checks = 0;
			end else if (cmd_tag[i] == "I") begin
				expect_init_word(16'(cmd_arg[i]));
			end else if (cmd_tag[i] == "P") begin
				press_button(cmd_arg[i]);
			end else if (cmd_tag[i] == "G") begin
				glitch_button(cmd_arg[i]);
			end else if (cmd_tag[i] == "F") begin
				follow_frame(cmd_rows[i], cmd_arg[i]);
			end else begin
				$display("Golden file has an unknown tag %s", cmd_tag[i]);
				note_error();
			end
		end
		close_test();

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d", tests_run,
		         tests_failed, checks, errors);
		if (errors == 0 && tests_run > 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Generous bound from the number of expected frames
	initial begin
		int limit;
		wait (golden_loaded);
		limit = 2 * (frame_lines + 4) * `TICK_CYCLES;
		repeat (limit) @(posedge clock_50);
		$display("Timeout: the run did not finish within %0d clock cycles", limit);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/car_game_golden.txt ====
# Tag and hex fields: T name | I word | P low_cycles | G pulses
# F passes row0 row1 row2 row3 row4 row5 row6 row7
T init
I 0C00
I 0900
I 0B07
I 0A0A
I 0F00
T idle_display
F 3 7C 7C 7C 7C 7C 7C 7C 7C
T glitch_reject
G 3
F 6 7C 7C 7C 7C 7C 7C 7C 7C
T game_progression
P 12C
F 1 00 00 00 00 00 00 00 00
F 1 01 00 00 00 00 00 00 00
F 1 08 01 00 00 00 00 00 00
F 1 40 08 01 00 00 00 00 00
F 1 02 40 08 01 00 00 00 00
F 1 10 02 40 08 01 00 00 00
F 1 80 10 02 40 08 01 00 00
F 1 04 80 10 02 40 08 01 00
F 1 20 04 80 10 02 40 08 01
F 1 02 20 04 80 10 02 40 08
F 1 10 02 20 04 80 10 02 40
F 1 80 10 02 20 04 80 10 02
F 1 04 80 10 02 20 04 80 10
F 1 20 04 80 10 02 20 04 80
F 1 01 20 04 80 10 02 20 04
F 1 08 01 20 04 80 10 02 20
F 1 40 08 01 20 04 80 10 02
T game_end_return
F 2 10 10 10 10 10 10 10 10
P 12C
F 2 7C 7C 7C 7C 7C 7C 7C 7C

// ==== sources.f ====
+incdir+verilog
verilog/game_pkg.sv
verilog/display_pkg.sv
verilog/button_debounce.sv
verilog/game_control.sv
verilog/road_scroll.sv
verilog/matrix_driver.sv
verilog/car_game_top.sv
tb/max7219_monitor.sv
tb/tb_car_game.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the car game testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f sources.f --top-module tb_car_game -o tb_car_game
./obj_dir/tb_car_game > sim.log
cat sim.log
if grep -q "^ALL CHECKS PASSED$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
